/* vgaText_defs.svh */
`ifndef VGA_TEXT_DEFS_SVH
`define VGA_TEXT_DEFS_SVH

// horizontal raster, in pixel clocks
`define VGA_LINE_COLS    800 // whole line
`define VGA_ACTIVE_COLS  640 // visible pixels
`define VGA_HSYNC_START  656 // end of front porch
`define VGA_HSYNC_STOP   720 // start of back porch

// vertical raster, in lines
`define VGA_FRAME_ROWS   501 // whole frame
`define VGA_ACTIVE_ROWS  480 // visible lines
`define VGA_VSYNC_START  483 // end of front porch
`define VGA_VSYNC_STOP   487 // start of back porch

// character grid and glyph cell
`define TEXT_COLS        64
`define TEXT_ROWS        32
`define FONT_COLS        10 // pixels per glyph row
`define FONT_ROWS        15 // glyph rows shown per cell

// raster position to video bit, in clocks
`define VGA_PIPE_DEPTH   3

`endif

/* vgaScanPkg.sv */
`default_nettype none

`include "vgaText_defs.svh"

package vgaScanPkg;

  typedef logic [$clog2(`VGA_LINE_COLS)-1:0] hCount_t; // 0 .. 799
  typedef logic [$clog2(`VGA_FRAME_ROWS)-1:0] vCount_t; // 0 .. 500

  typedef enum logic [3:0] {
    sActive = 4'd0, // line states
    sHFront = 4'd1,
    sHSync  = 4'd2,
    sHBack  = 4'd3,
    sVFront = 4'd4, // frame states
    sVSync  = 4'd5,
    sVBack  = 4'd6,
    sInit   = 4'd7  // one cycle after reset
  } scanState_t;

endpackage

`default_nettype wire

/* vgaTextPkg.sv */
`default_nettype none

`include "vgaText_defs.svh"

package vgaTextPkg;

  typedef logic [7:0] charCode_t;

  // row * 64 + column
  typedef logic [$clog2(`TEXT_COLS * `TEXT_ROWS)-1:0] textAddr_t;

  // code * 16 + glyph row, glyph row 15 never displayed
  typedef logic [$bits(charCode_t) + $clog2(`FONT_ROWS)-1:0] fontAddr_t;

  typedef logic [`FONT_COLS-1:0] glyphRow_t; // bit 0 is leftmost

endpackage

`default_nettype wire

/* rangeCounter.sv */
`timescale 1ns/100ps
`default_nettype none

module rangeCounter #(
  parameter int minValue = 0,
  parameter int maxValue = 255,
  localparam int countWidth = $clog2(maxValue + 1)
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  en,
  output logic [countWidth-1:0] count,
  output logic                  wrap
);

  logic atMax;

  assign atMax = (count == countWidth'(maxValue));
  assign wrap  = en && atMax; // last enabled step before going back to min

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= countWidth'(minValue);
    end else if (en) begin
      if (atMax) begin
        count <= countWidth'(minValue);
      end else begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* dualPortRam.sv */
`timescale 1ns/100ps
`default_nettype none

module dualPortRam #(
  parameter int dataWidth = 8,
  parameter int addrWidth = 11
) (
  input  logic                 clk,
  input  logic                 we,
  input  logic [addrWidth-1:0] wrAddr,
  input  logic [dataWidth-1:0] wrData,
  input  logic [addrWidth-1:0] rdAddr,
  output logic [dataWidth-1:0] rdData
);

  localparam int depth = 2 ** addrWidth;

  logic [dataWidth-1:0] mem [depth];

  // host side
  always_ff @(posedge clk) begin
    if (we) begin
      mem[wrAddr] <= wrData;
    end
  end

  // raster side, one cycle read latency
  always_ff @(posedge clk) begin
    rdData <= mem[rdAddr];
  end

endmodule

`default_nettype wire

/* scanTiming.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vgaText_defs.svh"

module scanTiming (
  input  logic                clk,
  input  logic                reset,
  output vgaScanPkg::hCount_t hCount,
  output vgaScanPkg::vCount_t vCount,
  output logic                lineWrap,
  output logic                frameWrap,
  output logic                scanActive,
  output logic                hsyncRaw,
  output logic                vsyncRaw
);
  import vgaScanPkg::*;

  scanState_t state;

  logic initState;
  logic activeEnd;    // last visible pixel of a line
  logic hFrontEnd;    // last pixel before hsync
  logic hSyncEnd;     // last pixel of hsync
  logic lastActLine;
  logic vFrontEnd;
  logic vSyncEnd;
  logic lastLine;

  assign initState = (state == sInit);

  // pixel counter runs every clock, line counter steps at each line end
  rangeCounter #(
    .minValue(0),
    .maxValue(`VGA_LINE_COLS - 1)
  ) hCounter (
    .clk  (clk),
    .reset(reset || initState),
    .en   (1'b1),
    .count(hCount),
    .wrap (lineWrap)
  );

  rangeCounter #(
    .minValue(0),
    .maxValue(`VGA_FRAME_ROWS - 1)
  ) vCounter (
    .clk  (clk),
    .reset(reset || initState),
    .en   (lineWrap),
    .count(vCount),
    .wrap (frameWrap)
  );

  // compares one step ahead so the state lines up with the counters
  assign activeEnd   = (hCount == `VGA_ACTIVE_COLS - 1);
  assign hFrontEnd   = (hCount == `VGA_HSYNC_START - 1);
  assign hSyncEnd    = (hCount == `VGA_HSYNC_STOP - 1);
  assign lastActLine = (vCount == `VGA_ACTIVE_ROWS - 1);
  assign vFrontEnd   = (vCount == `VGA_VSYNC_START - 1);
  assign vSyncEnd    = (vCount == `VGA_VSYNC_STOP - 1);
  assign lastLine    = (vCount == `VGA_FRAME_ROWS - 1);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= sInit;
    end else begin
      case (state)
        sActive: begin
          if (activeEnd) state <= sHFront;
        end
        sHFront: begin
          if (hFrontEnd) state <= sHSync;
        end
        sHSync: begin
          if (hSyncEnd) state <= sHBack;
        end
        sHBack: begin
          if (lineWrap) state <= lastActLine ? sVFront : sActive;
        end
        sVFront: begin
          if (lineWrap && vFrontEnd) state <= sVSync;
        end
        sVSync: begin
          if (lineWrap && vSyncEnd) state <= sVBack;
        end
        sVBack: begin
          // rejoin the line states at the hsync of the final line
          if (lastLine && hFrontEnd) state <= sHSync;
        end
        sInit: begin
          state <= sActive;
        end
        default: begin
          state <= sInit;
        end
      endcase
    end
  end

  assign scanActive = (state == sActive);

  // syncs straight from the counters, active high
  assign hsyncRaw = (hCount >= `VGA_HSYNC_START) && (hCount < `VGA_HSYNC_STOP);
  assign vsyncRaw = (vCount >= `VGA_VSYNC_START) && (vCount < `VGA_VSYNC_STOP);

endmodule

`default_nettype wire

/* glyphFetch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vgaText_defs.svh"

module glyphFetch (
  input  logic                  clk,
  input  logic                  reset,
  input  vgaScanPkg::hCount_t   hCount,
  input  vgaScanPkg::vCount_t   vCount,
  input  logic                  lineWrap,
  input  logic                  frameWrap,
  input  logic                  scanActive,
  input  logic                  hsyncRaw,
  input  logic                  vsyncRaw,
  output vgaTextPkg::textAddr_t textRdAddr,
  input  vgaTextPkg::charCode_t charCode,
  output vgaTextPkg::fontAddr_t fontRdAddr,
  input  vgaTextPkg::glyphRow_t glyphRow,
  output logic                  video,
  output logic                  hsync,
  output logic                  vsync,
  output logic                  dataEnable
);
  import vgaTextPkg::*;

  logic [$clog2(`FONT_COLS)-1:0] fontCol;
  logic [$clog2(`FONT_ROWS)-1:0] fontRow;
  logic [$clog2(`TEXT_COLS)-1:0] textCol;
  logic [$clog2(`TEXT_COLS)-1:0] fetchCol;
  logic [$clog2(`TEXT_ROWS)-1:0] textRow;
  logic fontColWrap;
  logic textColWrap;
  logic fontRowWrap;
  logic cellStart;
  logic loadGlyph;
  glyphRow_t pixels;
  logic [`VGA_PIPE_DEPTH-1:0] activePipe;
  logic [`VGA_PIPE_DEPTH-1:0] hsyncPipe;
  logic [`VGA_PIPE_DEPTH-1:0] vsyncPipe;

  rangeCounter #(.minValue(0), .maxValue(`FONT_COLS - 1)) fontColCnt (
    .clk(clk), .reset(reset || lineWrap), .en(scanActive),
    .count(fontCol), .wrap(fontColWrap)
  );
  rangeCounter #(.minValue(0), .maxValue(`TEXT_COLS - 1)) textColCnt (
    .clk(clk), .reset(reset || lineWrap), .en(fontColWrap),
    .count(textCol), .wrap(textColWrap)
  );

  // rows step when the visible part of a line ends, so the blank
  // interval already fetches with the next line's row
  rangeCounter #(.minValue(0), .maxValue(`FONT_ROWS - 1)) fontRowCnt (
    .clk(clk), .reset(reset || frameWrap),
    .en(textColWrap && (vCount < `VGA_ACTIVE_ROWS)),
    .count(fontRow), .wrap(fontRowWrap)
  );
  rangeCounter #(.minValue(0), .maxValue(`TEXT_ROWS - 1)) textRowCnt (
    .clk(clk), .reset(reset || frameWrap), .en(fontRowWrap),
    .count(textRow), .wrap()
  );

  // prefetch the cell after the current one; column 0 during the
  // last cell and the blank, ready for the next line
  always_comb begin
    if (scanActive && (hCount < `VGA_ACTIVE_COLS - `FONT_COLS)) begin
      fetchCol = textCol + 1'b1;
    end else begin
      fetchCol = '0;
    end
  end

  assign textRdAddr = {textRow, fetchCol};
  assign fontRdAddr = {charCode, fontRow}; // charCode is a registered RAM output

  assign cellStart = scanActive && (fontCol == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      loadGlyph <= 1'b0;
    end else begin
      loadGlyph <= cellStart; // glyph row valid one cycle after the cell starts
    end
  end

  always_ff @(posedge clk) begin
    if (loadGlyph) begin
      pixels <= glyphRow;
    end else begin
      pixels <= pixels >> 1; // next pixel to the left edge
    end
  end

  // delay active and syncs to meet the video bit
  always_ff @(posedge clk) begin
    if (reset) begin
      activePipe <= '0;
      hsyncPipe  <= '0;
      vsyncPipe  <= '0;
      video      <= 1'b0;
    end else begin
      activePipe <= {activePipe[`VGA_PIPE_DEPTH-2:0], scanActive};
      hsyncPipe  <= {hsyncPipe[`VGA_PIPE_DEPTH-2:0], hsyncRaw};
      vsyncPipe  <= {vsyncPipe[`VGA_PIPE_DEPTH-2:0], vsyncRaw};
      video      <= pixels[0] && activePipe[`VGA_PIPE_DEPTH-2];
    end
  end

  assign dataEnable = activePipe[`VGA_PIPE_DEPTH-1];
  assign hsync      = hsyncPipe[`VGA_PIPE_DEPTH-1];
  assign vsync      = vsyncPipe[`VGA_PIPE_DEPTH-1];

endmodule

`default_nettype wire

/* vgaText.sv */
`timescale 1ns/100ps
`default_nettype none

module vgaText (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  textWe,
  input  vgaTextPkg::textAddr_t textWrAddr,
  input  vgaTextPkg::charCode_t textWrData,
  input  logic                  fontWe,
  input  vgaTextPkg::fontAddr_t fontWrAddr,
  input  vgaTextPkg::glyphRow_t fontWrData,
  output logic                  video,
  output logic                  hsync,
  output logic                  vsync,
  output logic                  dataEnable
);
  import vgaScanPkg::*;
  import vgaTextPkg::*;

  hCount_t   hCount;
  vCount_t   vCount;
  logic      lineWrap;
  logic      frameWrap;
  logic      scanActive;
  logic      hsyncRaw;
  logic      vsyncRaw;
  textAddr_t textRdAddr;
  charCode_t charCode;
  fontAddr_t fontRdAddr;
  glyphRow_t glyphRow;

  scanTiming timing (
    .clk(clk), .reset(reset),
    .hCount(hCount), .vCount(vCount),
    .lineWrap(lineWrap), .frameWrap(frameWrap),
    .scanActive(scanActive), .hsyncRaw(hsyncRaw), .vsyncRaw(vsyncRaw)
  );

  dualPortRam #(.dataWidth($bits(charCode_t)), .addrWidth($bits(textAddr_t))) textMem (
    .clk(clk), .we(textWe), .wrAddr(textWrAddr), .wrData(textWrData),
    .rdAddr(textRdAddr), .rdData(charCode)
  );

  dualPortRam #(.dataWidth($bits(glyphRow_t)), .addrWidth($bits(fontAddr_t))) fontMem (
    .clk(clk), .we(fontWe), .wrAddr(fontWrAddr), .wrData(fontWrData),
    .rdAddr(fontRdAddr), .rdData(glyphRow)
  );

  glyphFetch fetch (
    .clk(clk), .reset(reset),
    .hCount(hCount), .vCount(vCount),
    .lineWrap(lineWrap), .frameWrap(frameWrap),
    .scanActive(scanActive), .hsyncRaw(hsyncRaw), .vsyncRaw(vsyncRaw),
    .textRdAddr(textRdAddr), .charCode(charCode),
    .fontRdAddr(fontRdAddr), .glyphRow(glyphRow),
    .video(video), .hsync(hsync), .vsync(vsync), .dataEnable(dataEnable)
  );

endmodule

`default_nettype wire

/* vgaText_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vgaText_defs.svh"

module vgaText_checker (
  input logic clk,
  input logic reset,
  input logic video,
  input logic hsync,
  input logic vsync,
  input logic dataEnable
);

  localparam int lineCycles  = `VGA_LINE_COLS;
  localparam int frameCycles = `VGA_LINE_COLS * `VGA_FRAME_ROWS;
  localparam int lastLine    = `VGA_ACTIVE_ROWS - 1;

  logic [7:0]            textShadow [`TEXT_COLS * `TEXT_ROWS];
  logic [`FONT_COLS-1:0] fontShadow [4096];
  string  curTest = "startup";
  int     lineErrs, frameErrs, videoErrs;
  int     framesDone, framesStarted, lineIdx, xPos;
  longint cycle, deRise, deFall, hsRise, vsRise, frameStart;
  logic   prevDe, prevHs, prevVs, videoArm, videoOn, vsSeen, deFell, started;

  initial begin
    videoArm  = 1'b0;
    lineErrs  = 0;
    frameErrs = 0;
    videoErrs = 0;
  end

  // shadow copies of host writes
  task automatic writeText(input int addr, input logic [7:0] code);
    textShadow[addr] = code;
  endtask

  task automatic writeFont(input int addr, input logic [`FONT_COLS-1:0] row);
    fontShadow[addr] = row;
  endtask

  task automatic setTest(input string name);
    curTest = name;
  endtask

  task automatic armVideo();
    videoArm = 1'b1; // takes effect at the next frame start
  endtask

  function automatic logic expectedPixel(input int x, input int y);
    logic [7:0] code;
    logic [`FONT_COLS-1:0] row;
    code = textShadow[(y / `FONT_ROWS) * `TEXT_COLS + x / `FONT_COLS];
    row  = fontShadow[code * 16 + y % `FONT_ROWS];
    return row[x % `FONT_COLS];
  endfunction

  task automatic valueError(input string test, input string what, input longint expected,
                            input longint actual);
    $display("[FAIL] %s: %s expected %0d actual %0d", test, what, expected, actual);
  endtask

  always @(posedge clk) begin
    if (reset) begin
      cycle         <= 0;
      prevDe        <= 1'b0;
      prevHs        <= 1'b0;
      prevVs        <= 1'b0;
      vsSeen        <= 1'b0;
      deFell        <= 1'b0;
      started       <= 1'b0;
      videoOn       <= 1'b0;
      framesDone    <= 0;
      framesStarted <= 0;
      lineIdx       <= 0;
      xPos          <= 0;
      deRise        <= 0;
      deFall        <= 0;
      hsRise        <= 0;
      vsRise        <= 0;
      frameStart    <= 0;
    end else begin : track
      int x;
      int y;
      int lineHits;
      int frameHits;
      logic on;
      x         = prevDe ? xPos : 0;
      y         = lineIdx;
      on        = videoOn;
      lineHits  = 0;
      frameHits = 0;
      cycle  <= cycle + 1;
      prevDe <= dataEnable;
      prevHs <= hsync;
      prevVs <= vsync;
      if (dataEnable && !prevDe) begin
        if (vsSeen || !started) begin // first line of a frame
          if (started && cycle - frameStart != frameCycles) begin
            frameHits++;
            valueError("frameTiming", "frame length", frameCycles, cycle - frameStart);
          end
          frameStart    <= cycle;
          framesStarted <= framesStarted + 1;
          videoOn       <= videoArm;
          vsSeen        <= 1'b0;
          started       <= 1'b1;
          on            = videoArm;
          y             = 0;
        end else begin
          if (cycle - deRise != lineCycles) begin
            lineHits++;
            valueError("lineTiming", "line length", lineCycles, cycle - deRise);
          end
          y = lineIdx + 1;
        end
        deRise  <= cycle;
        lineIdx <= y;
      end
      if (dataEnable) begin
        if (on && video !== expectedPixel(x, y)) begin
          videoErrs <= videoErrs + 1;
          if (videoErrs < 20) begin
            $display("[FAIL] %s: video at x %0d y %0d expected %0b actual %0b",
                     curTest, x, y, expectedPixel(x, y), video);
          end
        end
        xPos <= x + 1;
      end else if (started && video !== 1'b0) begin
        videoErrs <= videoErrs + 1;
        $display("video high outside active area in %s", curTest);
      end
      if (!dataEnable && prevDe) begin
        if (xPos != `VGA_ACTIVE_COLS) begin
          lineHits++;
          valueError("lineTiming", "dataEnable cycles", `VGA_ACTIVE_COLS, xPos);
        end
        deFall <= cycle;
        deFell <= 1'b1;
        if (lineIdx == lastLine) framesDone <= framesDone + 1;
      end
      if (hsync && !prevHs) begin
        hsRise <= cycle;
        if (deFell) begin
          deFell <= 1'b0;
          if (cycle - deFall != 16) begin
            lineHits++;
            valueError("lineTiming", "hsync delay", 16, cycle - deFall);
          end
        end
      end
      if (!hsync && prevHs && cycle - hsRise != 64) begin
        lineHits++;
        valueError("lineTiming", "hsync width", 64, cycle - hsRise);
      end
      if (vsync && !prevVs) begin
        vsRise <= cycle;
        vsSeen <= 1'b1;
        if (lineIdx != lastLine) begin
          frameHits++;
          valueError("frameTiming", "active lines", `VGA_ACTIVE_ROWS, lineIdx + 1);
        end
        if (cycle - deRise != 4 * lineCycles) begin // 3 blank lines after the last line
          frameHits++;
          valueError("frameTiming", "vsync start", 4 * lineCycles, cycle - deRise);
        end
      end
      if (!vsync && prevVs && cycle - vsRise != 4 * lineCycles) begin
        frameHits++;
        valueError("frameTiming", "vsync width", 4 * lineCycles, cycle - vsRise);
      end
      lineErrs  <= lineErrs + lineHits;
      frameErrs <= frameErrs + frameHits;
    end
  end

endmodule

`default_nettype wire

/* vgaText_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module vgaText_assertions (
  input logic                   clk,
  input logic                   reset,
  input vgaScanPkg::scanState_t state,
  input logic                   lineWrap,
  input logic                   scanActive,
  input logic                   hsyncRaw,
  input logic                   vsyncRaw
);
  import vgaScanPkg::*;

  int failures = 0; // failed assertion count

  syncOutsideActive: assert property (@(posedge clk) disable iff (reset)
    scanActive |-> (!hsyncRaw && !vsyncRaw))
    else begin
      failures++;
      $error("sync high during active video");
    end

  lineWrapPulse: assert property (@(posedge clk) disable iff (reset)
    lineWrap |=> !lineWrap)
    else begin
      failures++;
      $error("lineWrap longer than one cycle");
    end

  // vertical back porch hands over to hsync of the last line, just as the counters enter sync
  vBackExit: assert property (@(posedge clk) disable iff (reset)
    (state == sVBack) |=> (state == sVBack) || ((state == sHSync) && $rose(hsyncRaw)))
    else begin
      failures++;
      $error("sVBack not followed by sHSync at the start of hsync");
    end

endmodule

bind scanTiming vgaText_assertions sva (
  .clk(clk), .reset(reset), .state(state), .lineWrap(lineWrap),
  .scanActive(scanActive), .hsyncRaw(hsyncRaw), .vsyncRaw(vsyncRaw)
);

`default_nettype wire

/* vgaText_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module vgaText_tb;
  import vgaTextPkg::*;

  localparam int clkPeriod      = 40;
  localparam int testFrames     = 5;
  localparam int frameCycles    = 800 * 501;
  localparam int watchdogCycles = (testFrames + 1) * frameCycles + 20000;
  localparam logic [31:0] lfsrSeed = 32'hf41e_0d5f;
  localparam logic [31:0] lfsrTaps = 32'h8020_0003;

  logic      clk;
  logic      reset;
  logic      textWe;
  textAddr_t textWrAddr;
  charCode_t textWrData;
  logic      fontWe;
  fontAddr_t fontWrAddr;
  glyphRow_t fontWrData;
  logic      video, hsync, vsync, dataEnable;
  logic [31:0] lfsr;
  int        passed, failed;

  vgaText uut (
    .clk(clk), .reset(reset),
    .textWe(textWe), .textWrAddr(textWrAddr), .textWrData(textWrData),
    .fontWe(fontWe), .fontWrAddr(fontWrAddr), .fontWrData(fontWrData),
    .video(video), .hsync(hsync), .vsync(vsync), .dataEnable(dataEnable)
  );

  vgaText_checker check (
    .clk(clk), .reset(reset), .video(video),
    .hsync(hsync), .vsync(vsync), .dataEnable(dataEnable)
  );

  always #(clkPeriod / 2) clk = ~clk;

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ lfsrTaps) : (s >> 1);
  endfunction

  task automatic randomBits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0]; // one step per bit
      lfsr = lfsrStep(lfsr);
    end
  endtask

  task automatic hostWrite(input logic doText, input int tAddr, input logic [7:0] code,
                           input logic doFont, input int fAddr, input logic [9:0] row);
    @(posedge clk);
    textWe     <= doText;
    textWrAddr <= textAddr_t'(tAddr);
    textWrData <= code;
    fontWe     <= doFont;
    fontWrAddr <= fontAddr_t'(fAddr);
    fontWrData <= row;
    if (doText) check.writeText(tAddr, code);
    if (doFont) check.writeFont(fAddr, row);
  endtask

  task automatic hostIdle();
    @(posedge clk);
    textWe <= 1'b0;
    fontWe <= 1'b0;
  endtask

  // text in the first 2048 cycles, font over all 4096
  task automatic fillMemories(input logic randomData);
    logic [31:0] code;
    logic [31:0] row;
    for (int a = 0; a < 4096; a++) begin
      code = '0;
      row  = '0;
      if (randomData) begin
        randomBits(8, code);
        randomBits(10, row);
      end
      hostWrite(a < 2048, a % 2048, code[7:0], 1'b1, a, row[9:0]);
    end
    hostIdle();
  endtask

  task automatic waitFrames(input int n);
    while (check.framesDone < n) @(posedge clk);
  endtask

  task automatic reportTest(input string name, input int errs);
    if (errs == 0) begin
      passed++;
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  initial begin
    int snap;
    logic [31:0] code;
    clk        = 1'b0;
    reset      = 1'b1;
    textWe     = 1'b0;
    textWrAddr = '0;
    textWrData = '0;
    fontWe     = 1'b0;
    fontWrAddr = '0;
    fontWrData = '0;
    lfsr       = lfsrSeed;
    passed     = 0;
    failed     = 0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    check.setTest("blankFrame");
    fillMemories(1'b0); // frame 0 is not compared
    check.armVideo();
    waitFrames(2);
    reportTest("blankFrame", check.videoErrs);
    snap = check.videoErrs;
    check.setTest("randomFrame");
    fillMemories(1'b1); // vertical blank before frame 2
    waitFrames(3);
    reportTest("randomFrame", check.videoErrs - snap);
    snap = check.videoErrs;
    check.setTest("liveSameFrame");
    while (check.framesStarted < 4 || check.lineIdx < 250) @(posedge clk);
    for (int a = 0; a < 15 * 64; a++) begin // text rows 0 to 14 already shown
      randomBits(8, code);
      hostWrite(1'b1, a, code[7:0], 1'b0, 0, '0);
    end
    hostIdle();
    waitFrames(4);
    reportTest("liveSameFrame", check.videoErrs - snap);
    snap = check.videoErrs;
    check.setTest("liveNextFrame");
    waitFrames(5);
    reportTest("liveNextFrame", check.videoErrs - snap);
    reportTest("lineTiming", check.lineErrs);
    reportTest("frameTiming", check.frameErrs);
    reportTest("assertions", uut.timing.sva.failures);
    $display("tests %0d, passed %0d, failed %0d", passed + failed, passed, failed);
    if (failed == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(watchdogCycles * clkPeriod);
    $display("watchdog expired after %0d cycles, run did not complete", watchdogCycles);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* vgaText.f */
+incdir+.
vgaScanPkg.sv
vgaTextPkg.sv
rangeCounter.sv
dualPortRam.sv
scanTiming.sv
glyphFetch.sv
vgaText.sv
vgaText_checker.sv
vgaText_assertions.sv
vgaText_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= vgaText_tb
FILELIST  ?= vgaText.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(BUILD_DIR)
